/* Bender.yml */
package:
  name: slink_ltssm

sources:
  - slink_pkg.sv
  - slink_lane_ctrl.sv
  - slink_os_gen.sv
  - slink_rx_train.sv
  - slink_ltssm_fsm.sv
  - slink_tx_lane_mux.sv
  - slink_ltssm.sv
  - target: simulation
    files:
      - slink_ltssm_properties.sv
      - slink_ltssm_tb.sv

/* sim.f */
slink_pkg.sv
slink_lane_ctrl.sv
slink_os_gen.sv
slink_rx_train.sv
slink_ltssm_fsm.sv
slink_tx_lane_mux.sv
slink_ltssm.sv
slink_ltssm_properties.sv
slink_ltssm_tb.sv

/* slink_lane_ctrl.sv */
module slink_lane_ctrl
  import slink_pkg::*;
#(
  parameter int NUM_TX_LANES = 4,
  parameter int NUM_RX_LANES = 4
)(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    enable,
  input  logic                    phy_clk_ready,
  input  logic [NUM_TX_LANES-1:0] phy_tx_ready,
  input  logic [NUM_RX_LANES-1:0] phy_rx_ready,
  input  lane_code_t              active_tx_lanes,
  input  lane_code_t              active_rx_lanes,
  input  logic                    lanes_on,
  output logic                    enable_sync,
  output logic                    clk_ready_sync,
  output logic                    all_ready,
  output logic [NUM_TX_LANES-1:0] phy_tx_en,
  output logic [NUM_RX_LANES-1:0] phy_rx_en
);

  localparam int SYNC_W = 2 + NUM_TX_LANES + NUM_RX_LANES;

  logic [SYNC_W-1:0]       sync_ff1, sync_ff2;
  logic [NUM_TX_LANES-1:0] tx_ready_sync, tx_mask;
  logic [NUM_RX_LANES-1:0] rx_ready_sync, rx_mask;

  // two flop chains over one vector of all inputs
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_ff1 <= '0;
      sync_ff2 <= '0;
    end else begin
      sync_ff1 <= {enable, phy_clk_ready, phy_tx_ready, phy_rx_ready};
      sync_ff2 <= sync_ff1;
    end
  end

  assign {enable_sync, clk_ready_sync, tx_ready_sync, rx_ready_sync} = sync_ff2;

  for (genvar i = 0; i < NUM_TX_LANES; i++) begin : g_tx_mask
    assign tx_mask[i] = lane_on(i, active_tx_lanes);
  end

  for (genvar i = 0; i < NUM_RX_LANES; i++) begin : g_rx_mask
    assign rx_mask[i] = lane_on(i, active_rx_lanes);
  end

  // inactive lanes may report anything
  assign all_ready = ((tx_ready_sync & tx_mask) == tx_mask) &&
                     ((rx_ready_sync & rx_mask) == rx_mask);

  assign phy_tx_en = tx_mask & {NUM_TX_LANES{lanes_on}};
  assign phy_rx_en = rx_mask & {NUM_RX_LANES{lanes_on}};

endmodule

/* slink_ltssm.sv */
module slink_ltssm
  import slink_pkg::*;
#(
  parameter int DATA_WIDTH      = 8,
  parameter int NUM_TX_LANES    = 4,
  parameter int NUM_RX_LANES    = 4,
  parameter int REGISTER_TXDATA = 1
)(
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               enable,
  input  logic [15:0]                        ts1_tx_count,
  input  logic [15:0]                        ts1_rx_count,
  input  logic [15:0]                        ts2_tx_count,
  input  logic [15:0]                        ts2_rx_count,
  input  logic [15:0]                        swi_clk_switch_time,
  input  logic [15:0]                        swi_p0_exit_time,
  input  logic [7:0]                         attr_sync_freq,
  input  lane_code_t                         active_tx_lanes,
  input  lane_code_t                         active_rx_lanes,
  input  logic                               phy_clk_ready,
  input  logic [NUM_TX_LANES-1:0]            phy_tx_ready,
  input  logic [NUM_RX_LANES-1:0]            phy_rx_ready,
  input  logic [NUM_RX_LANES-1:0]            rx_ts1_seen,
  input  logic [NUM_RX_LANES-1:0]            rx_ts2_seen,
  input  logic [NUM_RX_LANES-1:0]            rx_sds_seen,
  input  logic                               enter_px_state,
  input  logic                               link_active_req,
  input  logic [NUM_TX_LANES*DATA_WIDTH-1:0] link_data,
  output logic                               use_phy_clk,
  output logic                               phy_clk_en,
  output logic [NUM_TX_LANES-1:0]            phy_tx_en,
  output logic [NUM_RX_LANES-1:0]            phy_rx_en,
  output logic [NUM_RX_LANES-1:0]            phy_rx_align,
  output logic                               deskew_enable,
  output logic                               sds_sent,
  output logic                               ll_tx_valid,
  output logic                               in_px_state,
  output logic                               effect_update,
  output logic                               link_wake_n,
  output logic [NUM_TX_LANES*DATA_WIDTH-1:0] ltssm_data,
  output ltssm_state_t                       ltssm_state
);

  logic                  enable_sync, clk_ready_sync, all_ready, lanes_on;
  logic                  block_end, os_done, rx_align;
  logic                  count_ts1, count_ts2, train_clear;
  logic                  ts1_ok, ts2_ok, sds_ok;
  os_kind_t              os_kind;
  logic [DATA_WIDTH-1:0] lane_byte;

  slink_lane_ctrl #(
    .NUM_TX_LANES (NUM_TX_LANES),
    .NUM_RX_LANES (NUM_RX_LANES)
  ) u_lane_ctrl (
    .clk (clk), .reset (reset), .enable (enable), .phy_clk_ready (phy_clk_ready),
    .phy_tx_ready (phy_tx_ready), .phy_rx_ready (phy_rx_ready),
    .active_tx_lanes (active_tx_lanes), .active_rx_lanes (active_rx_lanes),
    .lanes_on (lanes_on), .enable_sync (enable_sync), .clk_ready_sync (clk_ready_sync),
    .all_ready (all_ready), .phy_tx_en (phy_tx_en), .phy_rx_en (phy_rx_en)
  );

  slink_os_gen #(.DATA_WIDTH (DATA_WIDTH)) u_os_gen (
    .clk (clk), .reset (reset), .os_kind (os_kind), .attr_sync_freq (attr_sync_freq),
    .block_end (block_end), .os_done (os_done), .lane_byte (lane_byte)
  );

  slink_rx_train #(.NUM_RX_LANES (NUM_RX_LANES)) u_rx_train (
    .clk (clk), .reset (reset), .rx_ts1_seen (rx_ts1_seen), .rx_ts2_seen (rx_ts2_seen),
    .rx_sds_seen (rx_sds_seen), .count_ts1 (count_ts1), .count_ts2 (count_ts2),
    .train_clear (train_clear), .ts1_rx_count (ts1_rx_count), .ts2_rx_count (ts2_rx_count),
    .ts1_ok (ts1_ok), .ts2_ok (ts2_ok), .sds_ok (sds_ok)
  );

  slink_ltssm_fsm u_fsm (
    .clk (clk), .reset (reset), .enable_sync (enable_sync), .clk_ready_sync (clk_ready_sync),
    .all_ready (all_ready), .block_end (block_end), .os_done (os_done),
    .ts1_ok (ts1_ok), .ts2_ok (ts2_ok), .sds_ok (sds_ok),
    .enter_px_state (enter_px_state), .link_active_req (link_active_req),
    .ts1_tx_count (ts1_tx_count), .ts2_tx_count (ts2_tx_count),
    .swi_clk_switch_time (swi_clk_switch_time), .swi_p0_exit_time (swi_p0_exit_time),
    .state (ltssm_state), .os_kind (os_kind), .count_ts1 (count_ts1),
    .count_ts2 (count_ts2), .train_clear (train_clear), .lanes_on (lanes_on),
    .use_phy_clk (use_phy_clk), .phy_clk_en (phy_clk_en), .rx_align (rx_align),
    .deskew_enable (deskew_enable), .sds_sent (sds_sent), .ll_tx_valid (ll_tx_valid),
    .in_px_state (in_px_state), .effect_update (effect_update), .link_wake_n (link_wake_n)
  );

  slink_tx_lane_mux #(
    .DATA_WIDTH      (DATA_WIDTH),
    .NUM_TX_LANES    (NUM_TX_LANES),
    .REGISTER_TXDATA (REGISTER_TXDATA)
  ) u_tx_lane_mux (
    .clk (clk), .reset (reset), .state (ltssm_state), .lane_byte (lane_byte),
    .link_data (link_data), .phy_tx_en (phy_tx_en), .ltssm_data (ltssm_data)
  );

  assign phy_rx_align = {NUM_RX_LANES{rx_align}};   // same request on every rx lane

endmodule

/* slink_ltssm_fsm.sv */
module slink_ltssm_fsm
  import slink_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         enable_sync,
  input  logic         clk_ready_sync,
  input  logic         all_ready,
  input  logic         block_end,
  input  logic         os_done,
  input  logic         ts1_ok,
  input  logic         ts2_ok,
  input  logic         sds_ok,
  input  logic         enter_px_state,
  input  logic         link_active_req,
  input  logic [15:0]  ts1_tx_count,
  input  logic [15:0]  ts2_tx_count,
  input  logic [15:0]  swi_clk_switch_time,
  input  logic [15:0]  swi_p0_exit_time,
  output ltssm_state_t state,
  output os_kind_t     os_kind,
  output logic         count_ts1,
  output logic         count_ts2,
  output logic         train_clear,
  output logic         lanes_on,
  output logic         use_phy_clk,
  output logic         phy_clk_en,
  output logic         rx_align,
  output logic         deskew_enable,
  output logic         sds_sent,
  output logic         ll_tx_valid,
  output logic         in_px_state,
  output logic         effect_update,
  output logic         link_wake_n
);

  ltssm_state_t state_in;
  logic [15:0]  timer, timer_in;   // switch/exit wait and sent OS count
  logic         lanes_on_in;
  logic         use_phy_clk_in;
  logic         phy_clk_en_in;
  logic         link_wake_n_in;
  logic         effect_update_in;

  always_comb begin
    state_in         = state;
    timer_in         = timer;
    lanes_on_in      = lanes_on;
    use_phy_clk_in   = use_phy_clk;
    phy_clk_en_in    = phy_clk_en;
    link_wake_n_in   = 1'b0;
    effect_update_in = 1'b0;

    case (state)
      IDLE: begin
        timer_in       = '0;
        lanes_on_in    = 1'b0;
        phy_clk_en_in  = enable_sync;
        link_wake_n_in = !enable_sync;
        if (enable_sync) begin
          state_in = WAIT_CLK;
        end
      end
      WAIT_CLK: begin
        if (clk_ready_sync) begin
          use_phy_clk_in = 1'b1;
          state_in       = SWITCH;
        end
      end
      SWITCH: begin
        if (timer == swi_clk_switch_time) begin
          lanes_on_in = 1'b1;
          if (all_ready) begin
            timer_in = '0;
            state_in = P0_TS1;
          end
        end else begin
          timer_in = timer + 16'd1;
        end
      end
      // --------------------
      // training states where the timer counts sent TS blocks
      P0_TS1: begin
        if (os_done) begin
          if (((timer >= ts1_tx_count) || ts2_ok) && ts1_ok) begin
            timer_in = '0;
            state_in = P0_TS2;
          end else if (timer < ts1_tx_count) begin
            timer_in = timer + 16'd1;
          end
        end
      end
      P0_TS2: begin
        if (os_done) begin
          if (((timer >= ts2_tx_count) || sds_ok) && ts2_ok) begin
            timer_in = '0;
            state_in = P0_SDS;
          end else if (timer < ts2_tx_count) begin
            timer_in = timer + 16'd1;
          end
        end
      end
      P0_SDS: begin
        if (block_end) begin
          state_in = P0;
        end
      end
      // --------------------
      // power states
      P0: begin
        link_wake_n_in = 1'b1;
        if (enter_px_state) begin
          timer_in = '0;
          state_in = P0_EXIT;
        end
      end
      P0_EXIT: begin
        link_wake_n_in = 1'b1;
        if (timer == swi_p0_exit_time) begin
          timer_in         = '0;
          lanes_on_in      = 1'b0;
          effect_update_in = 1'b1;
          state_in         = P1;
        end else begin
          timer_in = timer + 16'd1;
        end
      end
      P1: begin
        link_wake_n_in = !link_active_req;
        if (link_active_req) begin
          lanes_on_in = 1'b1;
          state_in    = P1_EXIT;
        end
      end
      P1_EXIT: begin
        if (all_ready) begin
          timer_in = '0;
          state_in = P0_TS1;
        end
      end
      default: state_in = IDLE;
    endcase

    // losing enable overrides everything
    if (!enable_sync) begin
      use_phy_clk_in = 1'b0;
      lanes_on_in    = 1'b0;
      state_in       = IDLE;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state         <= IDLE;
      timer         <= '0;
      lanes_on      <= 1'b0;
      use_phy_clk   <= 1'b0;
      phy_clk_en    <= 1'b0;
      rx_align      <= 1'b0;
      deskew_enable <= 1'b0;
      in_px_state   <= 1'b0;
      effect_update <= 1'b0;
      link_wake_n   <= 1'b1;
    end else begin
      state         <= state_in;
      timer         <= timer_in;
      lanes_on      <= lanes_on_in;
      use_phy_clk   <= use_phy_clk_in;
      phy_clk_en    <= phy_clk_en_in;
      rx_align      <= (state_in == P0_TS1) || (state_in == P1_EXIT);
      deskew_enable <= state_in inside {P0_TS1, P0_TS2, P0_SDS, P0, P0_EXIT, P1_EXIT};
      in_px_state   <= (state_in == P1);
      effect_update <= effect_update_in;
      link_wake_n   <= link_wake_n_in;
    end
  end

  assign os_kind = (state == P0_TS1) ? OS_TS1 :
                   (state == P0_TS2) ? OS_TS2 :
                   (state == P0_SDS) ? OS_SDS : OS_NONE;

  assign count_ts1   = (state == P0_TS1);
  assign count_ts2   = (state == P0_TS1) || (state == P0_TS2);
  assign train_clear = !(state inside {P0_TS1, P0_TS2, P0_SDS});
  assign sds_sent    = (state == P0_SDS) && block_end;   // last SDS beat
  assign ll_tx_valid = (state == P0);

endmodule

/* slink_ltssm_properties.sv */
module slink_ltssm_properties
  import slink_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input ltssm_state_t state,
  input logic         sds_sent,
  input logic         effect_update,
  input logic         lanes_on
);
  timeunit 1ns;
  timeprecision 1ps;

  sds_one_cycle: assert property (@(posedge clk) disable iff (reset) sds_sent |=> !sds_sent)
    else $error("sds_sent held longer than one cycle");

  // IDLE only when enable drops on the last SDS beat
  sds_leads_to_p0: assert property (@(posedge clk) disable iff (reset)
    sds_sent |=> state inside {P0, IDLE})
    else $error("sds_sent not followed by P0");

  // pulse and state register load on the same edge
  update_enters_p1: assert property (@(posedge clk) disable iff (reset)
    effect_update |-> state == P1)
    else $error("effect_update without state P1");

  lanes_off_idle_p1: assert property (@(posedge clk) disable iff (reset)
    (state inside {IDLE, P1}) |-> !lanes_on)
    else $error("lanes_on set in IDLE or P1");

endmodule

bind slink_ltssm_fsm slink_ltssm_properties props0 (
  .clk (clk), .reset (reset), .state (state), .sds_sent (sds_sent),
  .effect_update (effect_update), .lanes_on (lanes_on)
);

/* slink_ltssm_tb.sv */
module slink_ltssm_tb
  import slink_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_WIDTH   = 8;
  localparam int NUM_TX_LANES = 4;
  localparam int NUM_RX_LANES = 4;

  logic clk, reset, enable, phy_clk_ready, enter_px_state, link_active_req;
  logic [15:0] ts1_tx_count, ts1_rx_count, ts2_tx_count, ts2_rx_count;
  logic [15:0] swi_clk_switch_time, swi_p0_exit_time;
  logic [7:0]  attr_sync_freq;
  lane_code_t  active_tx_lanes, active_rx_lanes;
  logic [NUM_TX_LANES-1:0] phy_tx_ready, phy_tx_en;
  logic [NUM_RX_LANES-1:0] phy_rx_ready, rx_ts1_seen, rx_ts2_seen, rx_sds_seen;
  logic [NUM_RX_LANES-1:0] phy_rx_en, phy_rx_align;
  logic [NUM_TX_LANES*DATA_WIDTH-1:0] link_data, ltssm_data;
  logic use_phy_clk, phy_clk_en, deskew_enable, sds_sent, ll_tx_valid;
  logic in_px_state, effect_update, link_wake_n;
  ltssm_state_t ltssm_state;
  integer seed;

  slink_ltssm #(
    .DATA_WIDTH      (DATA_WIDTH),
    .NUM_TX_LANES    (NUM_TX_LANES),
    .NUM_RX_LANES    (NUM_RX_LANES),
    .REGISTER_TXDATA (1)
  ) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // error handling and compares
  task automatic stop_on_error();
    $display("tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_timeout(string what);
    $display("timed out waiting for %s", what);
    stop_on_error();
  endtask

  task automatic compare_state(string name, ltssm_state_t got, ltssm_state_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h (%s) expected %h (%s)", name, got, got.name(), exp, exp.name());
      stop_on_error();
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic compare_vec(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // body byte of the state unless the byte is a sync or header byte
  function automatic logic [7:0] training_byte(ltssm_state_t st, logic [7:0] got);
    if (got === SYNC_B0 || got === SYNC_B1 || got === TSX_BYTE0) begin
      return got;
    end
    return (st == P0_TS1) ? TS1_BYTEX : TS2_BYTEX;
  endfunction

  // --------------------
  task automatic check_reset_values();
    @(negedge clk);
    compare_state("ltssm_state", ltssm_state, IDLE);
    compare_bit("use_phy_clk", use_phy_clk, 1'b0);
    compare_bit("phy_clk_en", phy_clk_en, 1'b0);
    compare_vec("phy_tx_en", phy_tx_en, '0);
    compare_vec("phy_rx_en", phy_rx_en, '0);
    compare_bit("deskew_enable", deskew_enable, 1'b0);
    compare_bit("effect_update", effect_update, 1'b0);
    compare_bit("sds_sent", sds_sent, 1'b0);
    compare_bit("in_px_state", in_px_state, 1'b0);
    compare_bit("link_wake_n", link_wake_n, 1'b1);
  endtask

  task automatic bring_up_link();
    int n;
    @(posedge clk);
    enable <= 1'b1;
    n = 0;
    @(negedge clk);
    while (phy_clk_en !== 1'b1) begin
      n++;
      if (n > 10) report_timeout("phy_clk_en");
      @(negedge clk);
    end
    @(posedge clk);
    phy_clk_ready <= 1'b1;
    n = 0;
    @(negedge clk);
    while (use_phy_clk !== 1'b1) begin
      n++;
      if (n > 10) report_timeout("use_phy_clk");
      @(negedge clk);
    end
    n = 0;
    while (phy_tx_en === '0) begin
      n++;
      if (n > 20) report_timeout("lanes on");
      @(negedge clk);
    end
    compare_state("ltssm_state", ltssm_state, SWITCH);
    compare_vec("phy_tx_en", phy_tx_en, 4'b0011);
    compare_vec("phy_rx_en", phy_rx_en, 4'b1111);
    @(posedge clk);
    phy_tx_ready <= '1;
    phy_rx_ready <= '1;
    rx_ts1_seen  <= '1;
    rx_ts2_seen  <= '1;   // far end sends no SDS so TS2 runs its full count
  endtask

  task automatic watch_training_data(int limit);
    ltssm_state_t prev_state;
    logic         sds_seen;
    int           n, checked;
    n = 0;
    checked = 0;
    sds_seen = 1'b0;
    @(negedge clk);
    prev_state = ltssm_state;
    while (!sds_seen) begin
      n++;
      if (n > limit) report_timeout("sds_sent");
      @(negedge clk);
      if (prev_state inside {P0_TS1, P0_TS2}) begin   // data register lags one cycle
        compare_vec("ltssm_data lane 0", ltssm_data[7:0],
                    training_byte(prev_state, ltssm_data[7:0]));
        checked++;
      end
      if (ltssm_state == P0_TS1) begin
        compare_vec("phy_rx_align", phy_rx_align, 4'hf);
      end
      compare_vec("ltssm_data lanes 2-3", ltssm_data[31:16], '0);
      sds_seen = sds_sent;
      prev_state = ltssm_state;
    end
    if (checked == 0) begin
      $display("no training bytes were seen before sds_sent");
      stop_on_error();
    end
    n = 0;
    @(negedge clk);
    while (ltssm_state !== P0) begin
      n++;
      if (n > 5) report_timeout("state P0 after sds_sent");
      @(negedge clk);
    end
  endtask

  task automatic run_passthrough(int beats);
    logic [31:0] prev, cur;
    prev = link_data;
    for (int i = 0; i < beats; i++) begin
      @(posedge clk);
      cur = $random(seed);
      link_data <= cur;
      @(negedge clk);
      compare_state("ltssm_state", ltssm_state, P0);
      compare_bit("ll_tx_valid", ll_tx_valid, 1'b1);
      compare_bit("deskew_enable", deskew_enable, 1'b1);
      compare_vec("phy_rx_align", phy_rx_align, '0);
      compare_vec("ltssm_data", ltssm_data, prev & 32'h0000_ffff);
      prev = cur;
    end
  endtask

  task automatic power_down_and_wake();
    int   n, exit_cycles;
    logic update_seen;
    @(posedge clk);
    enter_px_state <= 1'b1;
    @(posedge clk);
    enter_px_state <= 1'b0;
    n = 0;
    exit_cycles = 0;
    update_seen = 1'b0;
    @(negedge clk);
    while (ltssm_state !== P1) begin
      if (ltssm_state == P0_EXIT) exit_cycles++;
      update_seen = update_seen | effect_update;
      n++;
      if (n > 50) report_timeout("state P1");
      @(negedge clk);
    end
    update_seen = update_seen | effect_update;
    compare_vec("P0_EXIT cycles", exit_cycles, swi_p0_exit_time + 16'd1);
    compare_bit("effect_update", update_seen, 1'b1);
    compare_vec("phy_tx_en", phy_tx_en, '0);
    compare_bit("in_px_state", in_px_state, 1'b1);
    compare_bit("link_wake_n", link_wake_n, 1'b1);
    @(negedge clk);
    compare_bit("effect_update", effect_update, 1'b0);   // single pulse
    @(posedge clk);
    link_active_req <= 1'b1;
    n = 0;
    @(negedge clk);
    while (link_wake_n !== 1'b0) begin
      n++;
      if (n > 5) report_timeout("link_wake_n low");
      @(negedge clk);
    end
    @(posedge clk);
    link_active_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (ltssm_state !== P0) begin
      n++;
      if (n > 400) report_timeout("state P0 after wake");
      @(negedge clk);
    end
    compare_bit("in_px_state", in_px_state, 1'b0);
    compare_bit("ll_tx_valid", ll_tx_valid, 1'b1);
  endtask

  task automatic drop_enable();
    int n;
    @(posedge clk);
    enable <= 1'b0;
    n = 0;
    @(negedge clk);
    while (ltssm_state !== IDLE) begin
      n++;
      if (n > 3) report_timeout("state IDLE after enable drop");   // 2 sync flops + state
      @(negedge clk);
    end
    compare_bit("use_phy_clk", use_phy_clk, 1'b0);
    compare_vec("phy_tx_en", phy_tx_en, '0);
  endtask

  // --------------------
  initial begin
    seed                = 32'h6c5a_1c57;
    reset               = 1'b1;
    enable              = 1'b0;
    ts1_tx_count        = 16'd2;
    ts1_rx_count        = 16'd2;
    ts2_tx_count        = 16'd2;
    ts2_rx_count        = 16'd2;
    swi_clk_switch_time = 16'd3;
    swi_p0_exit_time    = 16'd5;
    attr_sync_freq      = 8'd4;
    active_tx_lanes     = 3'd1;   // lanes 0 and 1
    active_rx_lanes     = 3'd2;   // all four
    phy_clk_ready       = 1'b0;
    phy_tx_ready        = '0;
    phy_rx_ready        = '0;
    rx_ts1_seen         = '0;
    rx_ts2_seen         = '0;
    rx_sds_seen         = '0;
    enter_px_state      = 1'b0;
    link_active_req     = 1'b0;
    link_data           = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    check_reset_values();
    bring_up_link();
    watch_training_data(400);
    run_passthrough(32);
    power_down_and_wake();
    drop_enable();
    $display("all tests passed");
    $finish;
  end

endmodule

/* slink_os_gen.sv */
module slink_os_gen
  import slink_pkg::*;
#(
  parameter int DATA_WIDTH = 8
)(
  input  logic                  clk,
  input  logic                  reset,
  input  os_kind_t              os_kind,
  input  logic [7:0]            attr_sync_freq,
  output logic                  block_end,
  output logic                  os_done,
  output logic [DATA_WIDTH-1:0] lane_byte
);

  localparam int BEAT_BYTES = DATA_WIDTH / 8;

  logic [3:0] byte_cnt;
  logic [7:0] sync_cnt;      // data blocks since last SYNC
  logic       sending_sync;
  logic       sync_blk;

  assign sync_blk  = sending_sync && (os_kind != OS_SDS);  // SDS never displaced
  assign block_end = (os_kind != OS_NONE) &&
                     (byte_cnt == 4'(OS_BLOCK_BYTES - BEAT_BYTES));
  assign os_done   = block_end && !sync_blk;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      byte_cnt     <= '0;
      sync_cnt     <= '0;
      sending_sync <= 1'b1;
    end else if (os_kind == OS_NONE) begin
      byte_cnt     <= '0;
      sync_cnt     <= '0;
      sending_sync <= 1'b1;    // first block is SYNC
    end else if (block_end) begin
      byte_cnt <= '0;
      if (sync_blk) begin
        sync_cnt     <= '0;
        sending_sync <= 1'b0;
      end else begin
        sync_cnt     <= sync_cnt + 8'd1;
        sending_sync <= (sync_cnt + 8'd1 == attr_sync_freq);
      end
    end else begin
      byte_cnt <= byte_cnt + 4'(BEAT_BYTES);
    end
  end

  // --------------------
  // lane bytes, lowest byte first
  always_comb begin : byte_sel
    logic [3:0] idx;
    lane_byte = '0;
    for (int k = 0; k < BEAT_BYTES; k++) begin
      idx = byte_cnt + 4'(k);
      case (os_kind)
        OS_NONE: lane_byte[8*k +: 8] = 8'h00;
        OS_SDS:  lane_byte[8*k +: 8] = (idx == 4'd0) ? SDS_BYTE0 : SDS_BYTEX;
        default: begin
          if (sync_blk) begin
            lane_byte[8*k +: 8] = idx[0] ? SYNC_B1 : SYNC_B0;
          end else if (idx == 4'd0) begin
            lane_byte[8*k +: 8] = TSX_BYTE0;
          end else begin
            lane_byte[8*k +: 8] = (os_kind == OS_TS1) ? TS1_BYTEX : TS2_BYTEX;
          end
        end
      endcase
    end
  end

endmodule

/* slink_pkg.sv */
package slink_pkg;

  // --------------------
  // link training states
  typedef enum logic [3:0] {
    IDLE,
    WAIT_CLK,
    SWITCH,
    P0_TS1,
    P0_TS2,
    P0_SDS,
    P0,
    P0_EXIT,
    P1,
    P1_EXIT
  } ltssm_state_t;

  // ordered set requested from the generator
  typedef enum logic [1:0] {
    OS_NONE,
    OS_TS1,
    OS_TS2,
    OS_SDS
  } os_kind_t;

  // --------------------
  // ordered set bytes
  localparam logic [7:0] SYNC_B0   = 8'hAA;
  localparam logic [7:0] SYNC_B1   = 8'h55;
  localparam logic [7:0] TSX_BYTE0 = 8'hBC;
  localparam logic [7:0] TS1_BYTEX = 8'h4A;
  localparam logic [7:0] TS2_BYTEX = 8'h45;
  localparam logic [7:0] SDS_BYTE0 = 8'hE1;
  localparam logic [7:0] SDS_BYTEX = 8'hC3;

  localparam int OS_BLOCK_BYTES = 16;

  // lane i active when i < 2**code
  typedef logic [2:0] lane_code_t;

  function automatic logic lane_on(int unsigned lane, lane_code_t code);
    return lane < (32'd1 << code);
  endfunction

endpackage

/* slink_rx_train.sv */
module slink_rx_train #(
  parameter int NUM_RX_LANES = 4
)(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [NUM_RX_LANES-1:0] rx_ts1_seen,
  input  logic [NUM_RX_LANES-1:0] rx_ts2_seen,
  input  logic [NUM_RX_LANES-1:0] rx_sds_seen,
  input  logic                    count_ts1,
  input  logic                    count_ts2,
  input  logic                    train_clear,
  input  logic [15:0]             ts1_rx_count,
  input  logic [15:0]             ts2_rx_count,
  output logic                    ts1_ok,
  output logic                    ts2_ok,
  output logic                    sds_ok
);

  logic [15:0] ts1_cnt;
  logic [15:0] ts2_cnt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ts1_cnt <= '0;
      ts2_cnt <= '0;
      sds_ok  <= 1'b0;
    end else if (train_clear) begin
      ts1_cnt <= '0;
      ts2_cnt <= '0;
      sds_ok  <= 1'b0;
    end else begin
      if (count_ts1 && (&rx_ts1_seen) && !(&ts1_cnt)) begin
        ts1_cnt <= ts1_cnt + 16'd1;
      end
      if (count_ts2 && (&rx_ts2_seen) && !(&ts2_cnt)) begin
        ts2_cnt <= ts2_cnt + 16'd1;
      end
      if (count_ts2 && rx_sds_seen[0]) begin
        sds_ok <= 1'b1;     // lane 0 only
      end
    end
  end

  // far end already ahead also counts as done
  assign ts1_ok = (ts1_cnt >= ts1_rx_count) || (ts2_cnt != 16'd0);
  assign ts2_ok = (ts2_cnt >= ts2_rx_count) || sds_ok;

endmodule

/* slink_tx_lane_mux.sv */
module slink_tx_lane_mux
  import slink_pkg::*;
#(
  parameter int DATA_WIDTH      = 8,
  parameter int NUM_TX_LANES    = 4,
  parameter int REGISTER_TXDATA = 1
)(
  input  logic                               clk,
  input  logic                               reset,
  input  ltssm_state_t                       state,
  input  logic [DATA_WIDTH-1:0]              lane_byte,
  input  logic [NUM_TX_LANES*DATA_WIDTH-1:0] link_data,
  input  logic [NUM_TX_LANES-1:0]            phy_tx_en,
  output logic [NUM_TX_LANES*DATA_WIDTH-1:0] ltssm_data
);

  logic                               link_phase;
  logic [NUM_TX_LANES*DATA_WIDTH-1:0] data_sel;

  assign link_phase = (state == P0) || (state == P0_EXIT);

  for (genvar i = 0; i < NUM_TX_LANES; i++) begin : g_lane
    assign data_sel[i*DATA_WIDTH +: DATA_WIDTH] =
      !phy_tx_en[i] ? '0 :
      link_phase    ? link_data[i*DATA_WIDTH +: DATA_WIDTH] : lane_byte;
  end

  if (REGISTER_TXDATA != 0) begin : g_reg
    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        ltssm_data <= '0;
      end else begin
        ltssm_data <= data_sel;    // one cycle to the PHY
      end
    end
  end else begin : g_comb
    assign ltssm_data = data_sel;
  end

endmodule
